// ==== Makefile ====
SIM        = verilator
TOP        = icache_tb
FILELIST   = all.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert -j 0
OBJ_DIR    = obj_dir
PASS_MSG   = SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
logic/icache_geom_pkg.sv
logic/icache_ctrl_pkg.sv
logic/tag_if.sv
logic/refill_if.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/icache_lru.sv
logic/icache_ctrl.sv
logic/icache_top.sv
tests/icache_tb.sv

// ==== logic/icache_ctrl.sv ====
`default_nettype none

module icache_ctrl (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     inst_req,
    input  icache_geom_pkg::addr_t   inst_addr,
    output logic                     inst_addr_ok,
    output logic                     inst_data_ok,

    input  logic                     cache_req,
    input  logic [2:0]               cache_op,
    input  icache_geom_pkg::addr_t   cache_addr,
    output logic                     cache_op_ok,

    output icache_geom_pkg::addr_t   araddr,
    output logic                     arvalid,
    input  logic                     arready,
    input  icache_geom_pkg::word_t   rdata,
    input  logic                     rlast,
    input  logic                     rvalid,
    output logic                     rready,

    input  icache_geom_pkg::way_t    victim_way,
    output logic                     lru_touch,
    tag_if.ctrl                      tags,
    refill_if.ctrl                   refill
);
    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    addr_t      lookup_addr;
    logic [2:0] op_reg;
    bank_t      beat_cnt;
    logic       cache_accept;
    logic       beat;

    // fetch wins over a cache op in the same cycle
    assign inst_addr_ok = inst_req &&
                          ((state == IDLE) || ((state == LOOKUP) && tags.hit));
    assign cache_accept = (state == IDLE) && cache_req && !inst_req;

    assign inst_data_ok = (state == LOOKUP) && tags.hit;
    assign lru_touch    = inst_data_ok;
    assign cache_op_ok  = (state == CACHE_OP);

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (inst_req)
                    next_state = LOOKUP;
                else if (cache_req)
                    next_state = CACHE_OP;
            end
            LOOKUP:
            begin
                if (!tags.hit)
                    next_state = MISS_AR;
                else if (!inst_req)
                    next_state = IDLE;
            end
            MISS_AR:
            begin
                if (arready)
                    next_state = REFILL;
            end
            REFILL:
            begin
                if (rvalid && rlast)
                    next_state = LOOKUP;
            end
            CACHE_OP:
                next_state = IDLE;
            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_ff @(posedge clk)
    begin
        if (inst_addr_ok)
        begin
            lookup_addr <= inst_addr;
        end
        else if (cache_accept)
        begin
            lookup_addr <= cache_addr;
            op_reg      <= cache_op;
        end
    end

    // refill burst
    assign arvalid = (state == MISS_AR);
    assign araddr  = {lookup_addr[$bits(addr_t) - 1:INDEX_LSB], {INDEX_LSB{1'b0}}};
    assign rready  = (state == REFILL);
    assign beat    = rready && rvalid;

    always_ff @(posedge clk)
    begin
        if (rst || (state == MISS_AR))
            beat_cnt <= '0;
        else if (beat)
            beat_cnt <= beat_cnt + 1'b1;
    end

    assign refill.we    = beat;
    assign refill.way   = victim_way;
    assign refill.bank  = beat_cnt;
    assign refill.wdata = rdata;

    assign tags.lookup_addr = lookup_addr;
    assign tags.fill        = beat && rlast;
    assign tags.fill_way    = victim_way;

    // maintenance strobes last one cycle in CACHE_OP
    assign tags.inv_index = (state == CACHE_OP) && op_reg[OP_INDEX_INV];
    assign tags.inv_hit   = (state == CACHE_OP) && op_reg[OP_HIT_INV];
    assign tags.inv_way   = lookup_addr[OP_WAY_LSB +: $bits(way_t)];

endmodule

`default_nettype wire

// ==== logic/icache_ctrl_pkg.sv ====
`default_nettype none

package icache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_AR,
        REFILL,
        CACHE_OP
    } ctrl_state_t;

    // bit positions in cache_op
    localparam int OP_INDEX_INV = 0;
    localparam int OP_HIT_INV   = 2;

    // one line per burst of 8 incrementing beats of 4 bytes
    localparam logic [7:0] BURST_LEN  = 8'd7;
    localparam logic [2:0] BURST_SIZE = 3'd2;
    localparam logic [1:0] BURST_INCR = 2'd1;

    typedef logic [1:0] lru_rank_t;

endpackage

`default_nettype wire

// ==== logic/icache_data_array.sv ====
`default_nettype none

module icache_data_array (
    input  logic                         clk,
    input  icache_geom_pkg::addr_t       lookup_addr,
    input  icache_geom_pkg::way_mask_t   hit_mask,
    refill_if.data                       refill,
    output icache_geom_pkg::word_t       rdata
);
    import icache_geom_pkg::*;

    // one bank per word position in each way
    word_t mem [NUM_WAYS][WORDS_PER_LINE][NUM_SETS];

    index_t index;
    bank_t  bank;

    assign index = lookup_addr[INDEX_LSB +: $bits(index_t)];
    assign bank  = lookup_addr[BANK_LSB +: $bits(bank_t)];

    always_ff @(posedge clk)
    begin
        if (refill.we)
            mem[refill.way][refill.bank][index] <= refill.wdata;
    end

    // word of the hitting way or zero on a miss
    always_comb
    begin
        rdata = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (hit_mask[w])
                rdata = rdata | mem[w][bank][index];
        end
    end

endmodule

`default_nettype wire

// ==== logic/icache_geom_pkg.sv ====
`default_nettype none

package icache_geom_pkg;

    // 4 ways x 128 sets x 32-byte lines
    localparam int NUM_WAYS       = 4;
    localparam int NUM_SETS       = 128;
    localparam int WORDS_PER_LINE = 8;

    // address field offsets
    localparam int TAG_LSB   = 12;
    localparam int INDEX_LSB = 5;
    localparam int BANK_LSB  = 2;

    // index invalidate picks its way from address bits 13:12
    localparam int OP_WAY_LSB = 12;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    typedef logic [19:0] tag_t;
    typedef logic [6:0]  index_t;
    typedef logic [2:0]  bank_t;

    typedef logic [1:0] way_t;
    typedef logic [3:0] way_mask_t;

endpackage

`default_nettype wire

// ==== logic/icache_lru.sv ====
`default_nettype none

module icache_lru (
    input  logic                        clk,
    input  logic                        rst,
    input  icache_geom_pkg::index_t     index,
    input  logic                        touch,
    input  icache_geom_pkg::way_mask_t  hit_mask,
    output icache_geom_pkg::way_t       victim_way
);
    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;

    // order[s][0] is the most recent way, order[s][3] the least
    way_t order [NUM_SETS][NUM_WAYS];

    way_t      hit_way;
    lru_rank_t hit_rank;

    always_comb
    begin
        hit_way  = '0;
        hit_rank = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (hit_mask[w])
                hit_way = way_t'(w);
        end
        for (int r = 0; r < NUM_WAYS; r++)
        begin
            if (order[index][r] == hit_way)
                hit_rank = lru_rank_t'(r);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < NUM_SETS; s++)
                for (int r = 0; r < NUM_WAYS; r++)
                    order[s][r] <= way_t'(r);
        end
        else if (touch)
        begin
            // entries ahead of the hit slide back one place
            for (int r = 1; r < NUM_WAYS; r++)
            begin
                if (lru_rank_t'(r) <= hit_rank)
                    order[index][r] <= order[index][r - 1];
            end
            order[index][0] <= hit_way;
        end
    end

    assign victim_way = order[index][NUM_WAYS - 1];

endmodule

`default_nettype wire

// ==== logic/icache_tag_array.sv ====
`default_nettype none

module icache_tag_array (
    input  logic clk,
    input  logic rst,
    tag_if.tags  tags
);
    import icache_geom_pkg::*;

    tag_t      tag_mem [NUM_SETS][NUM_WAYS];
    way_mask_t valid   [NUM_SETS];

    index_t index;
    tag_t   tag;

    assign index = tags.lookup_addr[INDEX_LSB +: $bits(index_t)];
    assign tag   = tags.lookup_addr[TAG_LSB +: $bits(tag_t)];

    // compare all four ways of the set
    always_comb
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            tags.hit_mask[w] = valid[index][w] && (tag_mem[index][w] == tag);
        end
    end

    assign tags.hit = |tags.hit_mask;

    always_ff @(posedge clk)
    begin
        if (tags.fill)
            tag_mem[index][tags.fill_way] <= tag;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < NUM_SETS; s++)
                valid[s] <= '0;
        end
        else
        begin
            if (tags.fill)
                valid[index][tags.fill_way] <= 1'b1;

            if (tags.inv_index)
                valid[index][tags.inv_way] <= 1'b0;

            // drops every matching way of the set
            if (tags.inv_hit)
                valid[index] <= valid[index] & ~tags.hit_mask;
        end
    end

endmodule

`default_nettype wire

// ==== logic/icache_top.sv ====
`default_nettype none

module icache_top (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     inst_req,
    input  icache_geom_pkg::addr_t   inst_addr,
    output logic                     inst_addr_ok,
    output logic                     inst_data_ok,
    output icache_geom_pkg::word_t   inst_rdata,

    input  logic                     cache_req,
    input  logic [2:0]               cache_op,
    input  icache_geom_pkg::addr_t   cache_addr,
    output logic                     cache_op_ok,

    output icache_geom_pkg::addr_t   araddr,
    output logic [7:0]               arlen,
    output logic [2:0]               arsize,
    output logic [1:0]               arburst,
    output logic                     arvalid,
    input  logic                     arready,
    input  icache_geom_pkg::word_t   rdata,
    input  logic                     rlast,
    input  logic                     rvalid,
    output logic                     rready
);
    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;

    tag_if    tag_bus ();
    refill_if refill_bus ();

    way_t   victim_way;
    logic   lru_touch;
    index_t set_index;

    assign set_index = tag_bus.lookup_addr[INDEX_LSB +: $bits(index_t)];

    assign arlen   = BURST_LEN;
    assign arsize  = BURST_SIZE;
    assign arburst = BURST_INCR;

    icache_ctrl i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .cache_req    (cache_req),
        .cache_op     (cache_op),
        .cache_addr   (cache_addr),
        .cache_op_ok  (cache_op_ok),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rlast        (rlast),
        .rvalid       (rvalid),
        .rready       (rready),
        .victim_way   (victim_way),
        .lru_touch    (lru_touch),
        .tags         (tag_bus.ctrl),
        .refill       (refill_bus.ctrl)
    );

    icache_tag_array i_tag_array (
        .clk  (clk),
        .rst  (rst),
        .tags (tag_bus.tags)
    );

    icache_data_array i_data_array (
        .clk         (clk),
        .lookup_addr (tag_bus.lookup_addr),
        .hit_mask    (tag_bus.hit_mask),
        .refill      (refill_bus.data),
        .rdata       (inst_rdata)
    );

    icache_lru i_lru (
        .clk        (clk),
        .rst        (rst),
        .index      (set_index),
        .touch      (lru_touch),
        .hit_mask   (tag_bus.hit_mask),
        .victim_way (victim_way)
    );

endmodule

`default_nettype wire

// ==== logic/refill_if.sv ====
`default_nettype none

interface refill_if;
    import icache_geom_pkg::*;

    logic  we;
    way_t  way;
    bank_t bank;
    word_t wdata;

    modport ctrl (output we, way, bank, wdata);
    modport data (input we, way, bank, wdata);

endinterface

`default_nettype wire

// ==== logic/tag_if.sv ====
`default_nettype none

interface tag_if;
    import icache_geom_pkg::*;

    addr_t     lookup_addr;
    logic      fill;
    way_t      fill_way;
    logic      inv_index;
    way_t      inv_way;
    logic      inv_hit;
    logic      hit;
    way_mask_t hit_mask;

    modport ctrl (
        output lookup_addr, fill, fill_way, inv_index, inv_way, inv_hit,
        input  hit, hit_mask
    );

    modport tags (
        input  lookup_addr, fill, fill_way, inv_index, inv_way, inv_hit,
        output hit, hit_mask
    );

endinterface

`default_nettype wire

// ==== tests/icache_stim.txt ====
// columns: op address expected_word refill(1 = AR burst expected)
// op: 1 fetch, 2 fetch pair (address, address+4), 3 index invalidate, 4 hit invalidate, 0 end
1 00400024 ffbf0024 1
1 00400038 ffbf0038 0
2 00400028 ffbf0028 0
1 100000a0 efff00a0 1
1 100010a4 efff10a4 1
1 100020a8 efff20a8 1
1 100030ac efff30ac 1
1 100000b0 efff00b0 0
1 100040b4 efff40b4 1
1 100000bc efff00bc 0
1 100020a0 efff20a0 0
1 100030b8 efff30b8 0
1 100040a0 efff40a0 0
1 100010b8 efff10b8 1
3 000010a0 00000000 0
1 100020a4 efff20a4 1
1 100030a0 efff30a0 0
4 100040a0 00000000 0
1 100040ac efff40ac 1
4 100050a0 00000000 0
1 100010a0 efff10a0 0
1 100020bc efff20bc 0
1 100030a4 efff30a4 0
1 100040b0 efff40b0 0
2 00400020 ffbf0020 0
0 00000000 00000000 0

// ==== tests/icache_tb.sv ====
`default_nettype none

module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;

    localparam int MAX_ENTRIES = 32;
    localparam int WAIT_LIMIT  = 200;

    // operation codes of the stimulus file
    localparam int STIM_END       = 0;
    localparam int STIM_FETCH     = 1;
    localparam int STIM_PAIR      = 2;
    localparam int STIM_INDEX_INV = 3;
    localparam int STIM_HIT_INV   = 4;

    logic       clk;
    logic       rst;
    logic       inst_req;
    addr_t      inst_addr;
    logic       inst_addr_ok;
    logic       inst_data_ok;
    word_t      inst_rdata;
    logic       cache_req;
    logic [2:0] cache_op;
    addr_t      cache_addr;
    logic       cache_op_ok;
    addr_t      araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic       arvalid;
    logic       arready;
    word_t      rdata;
    logic       rlast;
    logic       rvalid;
    logic       rready;

    logic [31:0] stim_mem [4 * MAX_ENTRIES];

    // reference model of tags, valid bits and recency order per set
    logic [19:0] model_tag   [128][4];
    logic        model_valid [128][4];
    logic [1:0]  model_order [128][4];

    int unsigned rand_state  = 31994;
    int          ar_count    = 0;
    addr_t       expect_line = '0;

    icache_top i_icache_top (.*);

    always
    begin
        #5 clk = ~clk;
    end

    task automatic fail_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_text(input string msg);
        $display("at %0t: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic int unsigned next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return (rand_state >> 16) & 32'h7fff;
    endfunction

    // memory word is the byte address with its upper half inverted
    function automatic word_t data_rule(input addr_t a);
        return {~a[31:16], a[15:0]};
    endfunction

    function automatic void move_to_front(input int set, input logic [1:0] way);
        int pos;
        pos = 0;
        for (int r = 0; r < 4; r++)
            if (model_order[set][r] == way)
                pos = r;
        for (int r = pos; r > 0; r--)
            model_order[set][r] = model_order[set][r - 1];
        model_order[set][0] = way;
    endfunction

    // returns 1 when the model expects a refill
    function automatic logic predict_fetch(input addr_t a);
        int         set;
        logic [1:0] way;
        logic       miss;
        set  = int'(a[11:5]);
        miss = 1'b1;
        way  = 2'd0;
        for (int w = 0; w < 4; w++)
        begin
            if (model_valid[set][w] && model_tag[set][w] == a[31:12])
            begin
                miss = 1'b0;
                way  = 2'(w);
            end
        end
        if (miss)
        begin
            way = model_order[set][3];
            model_tag[set][way]   = a[31:12];
            model_valid[set][way] = 1'b1;
        end
        move_to_front(set, way);
        return miss;
    endfunction

    task automatic wait_addr_ok();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!inst_addr_ok)
        begin
            waited++;
            if (waited > WAIT_LIMIT)
                fail_text("timed out waiting for the cache to accept a fetch");
            @(negedge clk);
        end
    endtask

    task automatic wait_data_ok(output int cycles);
        cycles = 1;
        @(negedge clk);
        while (!inst_data_ok)
        begin
            cycles++;
            if (cycles > WAIT_LIMIT)
                fail_text("timed out waiting for the fetch data to return");
            @(negedge clk);
        end
    endtask

    task automatic run_fetch(input addr_t a, input word_t exp_word, input logic exp_refill);
        logic miss;
        int   start_ars;
        int   cycles;
        miss = predict_fetch(a);
        assert (miss == exp_refill)
            else fail_value("stimulus refill flag", 32'(exp_refill), 32'(miss));
        assert (data_rule(a) == exp_word)
            else fail_value("stimulus word", exp_word, data_rule(a));
        expect_line = {a[31:5], 5'b0};
        start_ars   = ar_count;
        @(posedge clk);
        inst_req  <= 1'b1;
        inst_addr <= a;
        wait_addr_ok();
        @(posedge clk);
        inst_req <= 1'b0;
        wait_data_ok(cycles);
        assert (inst_rdata == exp_word)
            else fail_value("inst_rdata", inst_rdata, exp_word);
        assert (ar_count - start_ars == (miss ? 1 : 0))
            else fail_value("AR request count", ar_count - start_ars, miss ? 1 : 0);
        if (!miss)
        begin
            assert (cycles == 1) else fail_value("hit latency", cycles, 1);
        end
    endtask

    // second request is issued while the first one is returning
    task automatic run_pair(input addr_t a, input word_t exp_word, input logic exp_refill);
        addr_t second;
        logic  first_miss;
        logic  second_miss;
        int    start_ars;
        second      = a + 32'd4;
        first_miss  = predict_fetch(a);
        second_miss = predict_fetch(second);
        assert (!first_miss && !second_miss && !exp_refill)
            else fail_text("a fetch pair needs two words that are already cached");
        assert (data_rule(a) == exp_word)
            else fail_value("stimulus word", exp_word, data_rule(a));
        start_ars = ar_count;
        @(posedge clk);
        inst_req  <= 1'b1;
        inst_addr <= a;
        wait_addr_ok();
        @(posedge clk);
        inst_addr <= second;
        @(negedge clk);
        assert (inst_data_ok) else fail_value("inst_data_ok", 32'(inst_data_ok), 1);
        assert (inst_rdata == exp_word) else fail_value("inst_rdata", inst_rdata, exp_word);
        assert (inst_addr_ok) else fail_value("inst_addr_ok", 32'(inst_addr_ok), 1);
        @(posedge clk);
        inst_req <= 1'b0;
        @(negedge clk);
        assert (inst_data_ok) else fail_value("inst_data_ok", 32'(inst_data_ok), 1);
        assert (inst_rdata == data_rule(second))
            else fail_value("inst_rdata", inst_rdata, data_rule(second));
        assert (ar_count == start_ars)
            else fail_value("AR request count", ar_count - start_ars, 0);
    endtask

    task automatic run_cache_op(input int kind, input addr_t a);
        int         set;
        logic [2:0] op;
        set = int'(a[11:5]);
        if (kind == STIM_INDEX_INV)
        begin
            // way number in address bits 13:12
            model_valid[set][a[13:12]] = 1'b0;
            op = 3'b001;
        end
        else
        begin
            for (int w = 0; w < 4; w++)
                if (model_tag[set][w] == a[31:12])
                    model_valid[set][w] = 1'b0;
            op = 3'b100;
        end
        @(posedge clk);
        cache_req  <= 1'b1;
        cache_op   <= op;
        cache_addr <= a;
        @(negedge clk);
        assert (!cache_op_ok) else fail_value("cache_op_ok", 32'(cache_op_ok), 0);
        @(posedge clk);
        cache_req <= 1'b0;
        @(negedge clk);
        assert (cache_op_ok) else fail_value("cache_op_ok", 32'(cache_op_ok), 1);
        @(negedge clk);
        assert (!cache_op_ok) else fail_value("cache_op_ok", 32'(cache_op_ok), 0);
    endtask

    task automatic check_ar_request();
        assert (araddr == expect_line) else fail_value("araddr", araddr, expect_line);
        assert (arlen == 8'd7) else fail_value("arlen", 32'(arlen), 7);
        assert (arsize == 3'd2) else fail_value("arsize", 32'(arsize), 2);
        assert (arburst == 2'd1) else fail_value("arburst", 32'(arburst), 1);
    endtask

    // AXI read slave with random arready delays and gaps between beats
    initial
    begin : memory_model
        int unsigned gap;
        addr_t       base;
        forever
        begin
            @(negedge clk);
            if (!rst && arvalid)
            begin
                check_ar_request();
                base = araddr;
                ar_count++;
                gap = next_rand() % 4;
                repeat (gap)
                begin
                    @(posedge clk);
                    @(negedge clk);
                    assert (arvalid && araddr == base)
                        else fail_text("arvalid dropped or araddr moved before arready");
                end
                @(posedge clk);
                arready <= 1'b1;
                @(posedge clk);
                arready <= 1'b0;
                for (int b = 0; b < 8; b++)
                begin
                    gap = next_rand() % 3;
                    if (gap != 0)
                    begin
                        rvalid <= 1'b0;
                        rlast  <= 1'b0;
                        repeat (gap) @(posedge clk);
                    end
                    rvalid <= 1'b1;
                    rdata  <= data_rule(base + addr_t'(4 * b));
                    rlast  <= (b == 7);
                    @(negedge clk);
                    assert (rready) else fail_text("rready was low while a beat was offered");
                    @(posedge clk);
                end
                rvalid <= 1'b0;
                rlast  <= 1'b0;
            end
        end
    end

    initial
    begin : main
        logic [31:0] op;
        addr_t       addr;
        word_t       word;
        logic        refill_flag;
        int          entries;
        clk        = 1'b0;
        rst        = 1'b1;
        inst_req   = 1'b0;
        inst_addr  = '0;
        cache_req  = 1'b0;
        cache_op   = '0;
        cache_addr = '0;
        arready    = 1'b0;
        rdata      = '0;
        rlast      = 1'b0;
        rvalid     = 1'b0;
        entries    = 0;
        for (int i = 0; i < 4 * MAX_ENTRIES; i++)
            stim_mem[i] = '0;
        $readmemh("tests/icache_stim.txt", stim_mem);
        for (int s = 0; s < 128; s++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                model_tag[s][r]   = '0;
                model_valid[s][r] = 1'b0;
                model_order[s][r] = 2'(r);
            end
        end

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (i_icache_top.i_ctrl.state == IDLE)
            else fail_value("state", 32'(i_icache_top.i_ctrl.state), 32'(IDLE));
        assert (!(inst_addr_ok || inst_data_ok || arvalid || rready || cache_op_ok))
            else fail_text("a handshake output is high right after reset");

        for (int i = 0; i < MAX_ENTRIES; i++)
        begin
            op          = stim_mem[4 * i];
            addr        = stim_mem[4 * i + 1];
            word        = stim_mem[4 * i + 2];
            refill_flag = stim_mem[4 * i + 3][0];
            if (op == STIM_END)
                break;
            case (op)
                STIM_FETCH:     run_fetch(addr, word, refill_flag);
                STIM_PAIR:      run_pair(addr, word, refill_flag);
                STIM_INDEX_INV: run_cache_op(STIM_INDEX_INV, addr);
                STIM_HIT_INV:   run_cache_op(STIM_HIT_INV, addr);
                default:        fail_text("unknown operation code in the stimulus file");
            endcase
            entries++;
        end
        assert (entries > 0) else fail_text("the stimulus file holds no operations");

        repeat (2) @(posedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
